// ==== verilog/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

	localparam int IR_W = 4;

	// IEEE 1149.1 controller states
	typedef enum logic [3:0] {
		TAP_EXIT2_DR   = 4'h0,
		TAP_EXIT1_DR   = 4'h1,
		TAP_SHIFT_DR   = 4'h2,
		TAP_PAUSE_DR   = 4'h3,
		TAP_SELECT_IR  = 4'h4,
		TAP_UPDATE_DR  = 4'h5,
		TAP_CAPTURE_DR = 4'h6,
		TAP_SELECT_DR  = 4'h7,
		TAP_EXIT2_IR   = 4'h8,
		TAP_EXIT1_IR   = 4'h9,
		TAP_SHIFT_IR   = 4'hA,
		TAP_PAUSE_IR   = 4'hB,
		TAP_RTI        = 4'hC,
		TAP_UPDATE_IR  = 4'hD,
		TAP_CAPTURE_IR = 4'hE,
		TAP_TLR        = 4'hF
	} tap_state_t;

	// Instruction codes
	localparam logic [IR_W-1:0] IDCODE    = 4'h1;
	localparam logic [IR_W-1:0] DBG_ADDR  = 4'h8;
	localparam logic [IR_W-1:0] DBG_WRITE = 4'h9;
	localparam logic [IR_W-1:0] DBG_READ  = 4'hA;
	localparam logic [IR_W-1:0] BYPASS    = 4'hF;

	localparam logic [31:0] IDCODE_VALUE = 32'h1D43_C0B3;

endpackage

`default_nettype wire

// ==== verilog/debug_pkg.sv ====
`default_nettype none

package debug_pkg;

	localparam int DATA_W = 16;
	localparam int ADDR_W = 4;

	// Register map
	localparam logic [ADDR_W-1:0] REG_IBUF     = 4'd0;
	localparam logic [ADDR_W-1:0] REG_CDR_GAIN = 4'd1;
	localparam logic [ADDR_W-1:0] REG_PRBS     = 4'd2;
	localparam logic [ADDR_W-1:0] REG_RESET    = 4'd3;
	localparam logic [ADDR_W-1:0] REG_PHASE    = 4'd8;
	localparam logic [ADDR_W-1:0] REG_PRBS_ERR = 4'd9;

	// Bit 0 async, 1 main, 2 mdll ref, 3 mdll mon
	localparam int IBUF_W = 4;

	// Ki in the low nibble, Kp above it
	localparam int GAIN_W = 4;

	localparam int PRBS_EQN_W = 2;

	// Soft reset bits of REG_RESET
	localparam int RST_W        = 2;
	localparam int RST_CDR_BIT  = 0;
	localparam int RST_PRBS_BIT = 1;

endpackage

`default_nettype wire

// ==== verilog/jtag_pin_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_pin_sync (
	input  wire logic clk,
	input  wire logic reset_i,
	input  wire logic tck_i,
	input  wire logic tms_i,
	input  wire logic tdi_i,
	input  wire logic trst_n_i,
	output logic      tck_rise_o,
	output logic      tck_fall_o,
	output logic      tms_o,
	output logic      tdi_o,
	output logic      trst_o
);
	// Pin order is trst_n, tdi, tms, tck
	logic [3:0] sync1_q;
	logic [3:0] sync2_q;
	logic       tck_prev_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			sync1_q    <= 4'b1000;
			sync2_q    <= 4'b1000;
			tck_prev_q <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
			trst_o     <= 1'b0;
		end else begin
			sync1_q    <= {trst_n_i, tdi_i, tms_i, tck_i};
			sync2_q    <= sync1_q;
			tck_prev_q <= sync2_q[0];
			tck_rise_o <= sync2_q[0] & ~tck_prev_q;
			tck_fall_o <= ~sync2_q[0] & tck_prev_q;
			trst_o     <= ~sync2_q[3];
		end
	end

	// Aligned with the strobes
	always_ff @(posedge clk) begin
		tms_o <= sync2_q[1];
		tdi_o <= sync2_q[2];
	end

	assert property (@(posedge clk) disable iff (reset_i) !(tck_rise_o && tck_fall_o))
		else $error("tck rise and fall strobes overlap");

endmodule

`default_nettype wire

// ==== verilog/jtag_tap.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_tap #(
	parameter logic [31:0] IDCODE_VALUE = jtag_pkg::IDCODE_VALUE
) (
	input  wire logic                      clk,
	input  wire logic                      reset_i,
	input  wire logic                      tck_rise_i,
	input  wire logic                      tck_fall_i,
	input  wire logic                      tms_i,
	input  wire logic                      tdi_i,
	input  wire logic                      trst_i,
	input  wire logic                      dr_tdo_i,
	output logic [jtag_pkg::IR_W-1:0]      ir_o,
	output logic                           capture_dr_o,
	output logic                           shift_dr_o,
	output logic                           update_dr_o,
	output logic                           tdo_o
);
	import jtag_pkg::*;

	tap_state_t      state_q;
	tap_state_t      state_d;
	logic [IR_W-1:0] ir_q;
	logic [IR_W-1:0] ir_sr_q;
	logic [31:0]     idcode_sr_q;
	logic            bypass_q;
	logic            dr_bit;

	always_comb begin
		case (state_q)
			TAP_TLR:        state_d = tms_i ? TAP_TLR : TAP_RTI;
			TAP_RTI:        state_d = tms_i ? TAP_SELECT_DR : TAP_RTI;
			TAP_SELECT_DR:  state_d = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR: state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:   state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:   state_d = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:  state_d = tms_i ? TAP_SELECT_DR : TAP_RTI;
			TAP_SELECT_IR:  state_d = tms_i ? TAP_TLR : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR: state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:   state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:   state_d = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			TAP_UPDATE_IR:  state_d = tms_i ? TAP_SELECT_DR : TAP_RTI;
			default:        state_d = TAP_TLR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i || trst_i) begin
			state_q <= TAP_TLR;
		end else if (tck_rise_i) begin
			state_q <= state_d;
		end
	end

	// Instruction register, loaded when Update-IR is entered
	always_ff @(posedge clk) begin
		if (reset_i || trst_i) begin
			ir_q <= IDCODE;
		end else if (tck_rise_i) begin
			if (state_d == TAP_TLR) begin
				ir_q <= IDCODE;
			end else if (state_d == TAP_UPDATE_IR) begin
				ir_q <= ir_sr_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tck_rise_i && state_q == TAP_CAPTURE_IR) begin
			ir_sr_q <= {{(IR_W-2){1'b0}}, 2'b01};
		end else if (tck_rise_i && state_q == TAP_SHIFT_IR) begin
			ir_sr_q <= {tdi_i, ir_sr_q[IR_W-1:1]};
		end
	end

	assign capture_dr_o = tck_rise_i && (state_q == TAP_CAPTURE_DR);
	assign shift_dr_o   = tck_rise_i && (state_q == TAP_SHIFT_DR);
	assign update_dr_o  = tck_rise_i && (state_d == TAP_UPDATE_DR);

	always_ff @(posedge clk) begin
		if (capture_dr_o) begin
			bypass_q    <= 1'b0;
			idcode_sr_q <= IDCODE_VALUE;
		end else if (shift_dr_o) begin
			bypass_q    <= tdi_i;
			idcode_sr_q <= {tdi_i, idcode_sr_q[31:1]};
		end
	end

	// Unknown instructions fall back to bypass
	always_comb begin
		case (ir_q)
			IDCODE:                       dr_bit = idcode_sr_q[0];
			DBG_ADDR, DBG_WRITE, DBG_READ: dr_bit = dr_tdo_i;
			default:                      dr_bit = bypass_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			case (state_q)
				TAP_SHIFT_IR: tdo_o <= ir_sr_q[0];
				TAP_SHIFT_DR: tdo_o <= dr_bit;
				default:      tdo_o <= 1'b0;
			endcase
		end
	end

	assign ir_o = ir_q;

	assert property (@(posedge clk) $onehot0({capture_dr_o, shift_dr_o, update_dr_o}))
		else $error("more than one DR strobe active");

	assert property (@(posedge clk) disable iff (reset_i) !$isunknown(state_q))
		else $error("TAP state left the legal encoding");

endmodule

`default_nettype wire

// ==== verilog/debug_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_reg_file (
	input  wire logic                             clk,
	input  wire logic                             reset_i,
	input  wire logic [jtag_pkg::IR_W-1:0]        ir_i,
	input  wire logic                             capture_dr_i,
	input  wire logic                             shift_dr_i,
	input  wire logic                             update_dr_i,
	input  wire logic                             tdi_i,
	input  wire logic [debug_pkg::DATA_W-1:0]     phase_est_i,
	input  wire logic [debug_pkg::DATA_W-1:0]     prbs_err_i,
	output logic                                  dr_tdo_o,
	output logic [debug_pkg::IBUF_W-1:0]          ibuf_disable_o,
	output logic [debug_pkg::GAIN_W-1:0]          cdr_ki_o,
	output logic [debug_pkg::GAIN_W-1:0]          cdr_kp_o,
	output logic [debug_pkg::PRBS_EQN_W-1:0]      prbs_eqn_o,
	output logic                                  cdr_rstb_o,
	output logic                                  prbs_rstb_o
);
	import jtag_pkg::*;
	import debug_pkg::*;

	logic [ADDR_W-1:0]     addr_q;
	logic [DATA_W-1:0]     data_sr_q;
	logic [DATA_W-1:0]     read_word;
	logic                  data_sel;

	logic [IBUF_W-1:0]     ibuf_q;
	logic [GAIN_W-1:0]     ki_q;
	logic [GAIN_W-1:0]     kp_q;
	logic [PRBS_EQN_W-1:0] eqn_q;
	logic [RST_W-1:0]      rst_q;

	assign data_sel = (ir_i == DBG_READ) || (ir_i == DBG_WRITE);

	// Unmapped addresses read as zero
	always_comb begin
		read_word = '0;
		case (addr_q)
			REG_IBUF:     read_word[IBUF_W-1:0]     = ibuf_q;
			REG_CDR_GAIN: read_word[2*GAIN_W-1:0]   = {kp_q, ki_q};
			REG_PRBS:     read_word[PRBS_EQN_W-1:0] = eqn_q;
			REG_RESET:    read_word[RST_W-1:0]      = rst_q;
			REG_PHASE:    read_word                 = phase_est_i;
			REG_PRBS_ERR: read_word                 = prbs_err_i;
			default:      read_word                 = '0;
		endcase
	end

	// Address shifts straight in, LSB first
	always_ff @(posedge clk) begin
		if (reset_i) begin
			addr_q <= '0;
		end else if (shift_dr_i && ir_i == DBG_ADDR) begin
			addr_q <= {tdi_i, addr_q[ADDR_W-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (data_sel) begin
			if (capture_dr_i) begin
				data_sr_q <= read_word;
			end else if (shift_dr_i) begin
				data_sr_q <= {tdi_i, data_sr_q[DATA_W-1:1]};
			end
		end
	end

	// Read-only and unmapped addresses drop the write
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ibuf_q <= '0;
			ki_q   <= '0;
			kp_q   <= '0;
			eqn_q  <= '0;
			rst_q  <= '0;
		end else if (update_dr_i && ir_i == DBG_WRITE) begin
			case (addr_q)
				REG_IBUF: ibuf_q <= data_sr_q[IBUF_W-1:0];
				REG_CDR_GAIN: begin
					ki_q <= data_sr_q[GAIN_W-1:0];
					kp_q <= data_sr_q[2*GAIN_W-1:GAIN_W];
				end
				REG_PRBS:  eqn_q <= data_sr_q[PRBS_EQN_W-1:0];
				REG_RESET: rst_q <= data_sr_q[RST_W-1:0];
				default: ;
			endcase
		end
	end

	assign dr_tdo_o = (ir_i == DBG_ADDR) ? addr_q[0] : data_sr_q[0];

	assign ibuf_disable_o = ibuf_q;
	assign cdr_ki_o       = ki_q;
	assign cdr_kp_o       = kp_q;
	assign prbs_eqn_o     = eqn_q;

	// Domains held in reset while the system reset is active
	assign cdr_rstb_o  = rst_q[RST_CDR_BIT] & ~reset_i;
	assign prbs_rstb_o = rst_q[RST_PRBS_BIT] & ~reset_i;

	assert property (@(posedge clk)
		!$stable({ibuf_q, ki_q, kp_q, eqn_q, rst_q}) |-> $past(update_dr_i) || $past(reset_i))
		else $error("configuration changed without an update strobe");

endmodule

`default_nettype wire

// ==== verilog/jtag.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag #(
	parameter logic [31:0] IDCODE_VALUE = jtag_pkg::IDCODE_VALUE
) (
	input  wire logic                             clk,
	input  wire logic                             reset_i,
	input  wire logic                             tck_i,
	input  wire logic                             tms_i,
	input  wire logic                             tdi_i,
	input  wire logic                             trst_n_i,
	input  wire logic [debug_pkg::DATA_W-1:0]     phase_est_i,
	input  wire logic [debug_pkg::DATA_W-1:0]     prbs_err_i,
	output logic                                  tdo_o,
	output logic                                  disable_ibuf_async_o,
	output logic                                  disable_ibuf_main_o,
	output logic                                  disable_ibuf_mdll_ref_o,
	output logic                                  disable_ibuf_mdll_mon_o,
	output logic [debug_pkg::GAIN_W-1:0]          cdr_ki_o,
	output logic [debug_pkg::GAIN_W-1:0]          cdr_kp_o,
	output logic [debug_pkg::PRBS_EQN_W-1:0]      prbs_eqn_o,
	output logic                                  cdr_rstb_o,
	output logic                                  prbs_rstb_o
);
	import jtag_pkg::*;
	import debug_pkg::*;

	logic              tck_rise;
	logic              tck_fall;
	logic              tms_s;
	logic              tdi_s;
	logic              trst_s;
	logic [IR_W-1:0]   ir_value;
	logic              capture_dr;
	logic              shift_dr;
	logic              update_dr;
	logic              dr_tdo;
	logic [IBUF_W-1:0] ibuf_disable;

	jtag_pin_sync u_pin_sync (
		.clk        (clk),
		.reset_i    (reset_i),
		.tck_i      (tck_i),
		.tms_i      (tms_i),
		.tdi_i      (tdi_i),
		.trst_n_i   (trst_n_i),
		.tck_rise_o (tck_rise),
		.tck_fall_o (tck_fall),
		.tms_o      (tms_s),
		.tdi_o      (tdi_s),
		.trst_o     (trst_s)
	);

	jtag_tap #(
		.IDCODE_VALUE (IDCODE_VALUE)
	) u_tap (
		.clk          (clk),
		.reset_i      (reset_i),
		.tck_rise_i   (tck_rise),
		.tck_fall_i   (tck_fall),
		.tms_i        (tms_s),
		.tdi_i        (tdi_s),
		.trst_i       (trst_s),
		.dr_tdo_i     (dr_tdo),
		.ir_o         (ir_value),
		.capture_dr_o (capture_dr),
		.shift_dr_o   (shift_dr),
		.update_dr_o  (update_dr),
		.tdo_o        (tdo_o)
	);

	debug_reg_file u_reg_file (
		.clk            (clk),
		.reset_i        (reset_i),
		.ir_i           (ir_value),
		.capture_dr_i   (capture_dr),
		.shift_dr_i     (shift_dr),
		.update_dr_i    (update_dr),
		.tdi_i          (tdi_s),
		.phase_est_i    (phase_est_i),
		.prbs_err_i     (prbs_err_i),
		.dr_tdo_o       (dr_tdo),
		.ibuf_disable_o (ibuf_disable),
		.cdr_ki_o       (cdr_ki_o),
		.cdr_kp_o       (cdr_kp_o),
		.prbs_eqn_o     (prbs_eqn_o),
		.cdr_rstb_o     (cdr_rstb_o),
		.prbs_rstb_o    (prbs_rstb_o)
	);

	assign disable_ibuf_async_o    = ibuf_disable[0];
	assign disable_ibuf_main_o     = ibuf_disable[1];
	assign disable_ibuf_mdll_ref_o = ibuf_disable[2];
	assign disable_ibuf_mdll_mon_o = ibuf_disable[3];

endmodule

`default_nettype wire

// ==== test/jtag_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_tb;
	import jtag_pkg::*;
	import debug_pkg::*;

	logic        clk;
	logic        reset_i;
	logic        tck_i;
	logic        tms_i;
	logic        tdi_i;
	logic        trst_n_i;
	logic [15:0] phase_est_i;
	logic [15:0] prbs_err_i;
	logic        tdo_o;
	logic        disable_ibuf_async_o;
	logic        disable_ibuf_main_o;
	logic        disable_ibuf_mdll_ref_o;
	logic        disable_ibuf_mdll_mon_o;
	logic [3:0]  cdr_ki_o;
	logic [3:0]  cdr_kp_o;
	logic [1:0]  prbs_eqn_o;
	logic        cdr_rstb_o;
	logic        prbs_rstb_o;
	logic [15:0] cfg_obs;

	// Register map model, stored masked to the field widths
	logic [15:0] model_cfg [0:15];

	jtag DUT (
		.clk                     (clk),
		.reset_i                 (reset_i),
		.tck_i                   (tck_i),
		.tms_i                   (tms_i),
		.tdi_i                   (tdi_i),
		.trst_n_i                (trst_n_i),
		.phase_est_i             (phase_est_i),
		.prbs_err_i              (prbs_err_i),
		.tdo_o                   (tdo_o),
		.disable_ibuf_async_o    (disable_ibuf_async_o),
		.disable_ibuf_main_o     (disable_ibuf_main_o),
		.disable_ibuf_mdll_ref_o (disable_ibuf_mdll_ref_o),
		.disable_ibuf_mdll_mon_o (disable_ibuf_mdll_mon_o),
		.cdr_ki_o                (cdr_ki_o),
		.cdr_kp_o                (cdr_kp_o),
		.prbs_eqn_o              (prbs_eqn_o),
		.cdr_rstb_o              (cdr_rstb_o),
		.prbs_rstb_o             (prbs_rstb_o)
	);

	assign cfg_obs = {disable_ibuf_mdll_mon_o, disable_ibuf_mdll_ref_o, disable_ibuf_main_o,
		disable_ibuf_async_o, cdr_ki_o, cdr_kp_o, prbs_eqn_o, cdr_rstb_o, prbs_rstb_o};

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	initial begin
		repeat (100000) @(posedge clk);
		report_failure("Simulation timed out before all checks completed");
	end

	assert property (@(posedge clk) reset_i |-> !cdr_rstb_o && !prbs_rstb_o)
		else report_failure($sformatf("MISMATCH at %0t: domain resets got %b%b expected 00",
			$time, cdr_rstb_o, prbs_rstb_o));

	assert property (@(posedge clk) reset_i |=> tdo_o == 1'b0)
		else report_failure($sformatf("MISMATCH at %0t: tdo_o got %b expected 0", $time, tdo_o));

	function automatic logic [15:0] field_mask(input logic [3:0] addr);
		case (addr)
			REG_IBUF:     return 16'h000F;
			REG_CDR_GAIN: return 16'h00FF;
			REG_PRBS:     return 16'h0003;
			REG_RESET:    return 16'h0003;
			default:      return 16'h0000;
		endcase
	endfunction

	function automatic logic [15:0] expected_read(input logic [3:0] addr);
		if (addr == REG_PHASE) return phase_est_i;
		if (addr == REG_PRBS_ERR) return prbs_err_i;
		return model_cfg[addr];
	endfunction

	// Ki low nibble, Kp high nibble; bit 0 of REG_RESET is the CDR reset
	function automatic logic [15:0] expected_cfg();
		return {model_cfg[REG_IBUF][3:0], model_cfg[REG_CDR_GAIN][3:0],
			model_cfg[REG_CDR_GAIN][7:4], model_cfg[REG_PRBS][1:0],
			model_cfg[REG_RESET][0], model_cfg[REG_RESET][1]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
			else report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic wait_config(input logic [15:0] exp);
		int n;
		n = 0;
		while (cfg_obs !== exp && n < 40) begin
			@(negedge clk);
			n++;
		end
		check_value("configuration outputs", {16'h0, cfg_obs}, {16'h0, exp});
	endtask

	// One tck period, tdo sampled just before the rising edge
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		@(negedge clk);
		tck_i = 1'b0;
		tms_i = tms;
		tdi_i = tdi;
		repeat (6) @(negedge clk);
		tdo = tdo_o;
		tck_i = 1'b1;
		repeat (5) @(negedge clk);
	endtask

	task automatic tap_reset();
		logic b;
		repeat (5) tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic shift_ir(input logic [IR_W-1:0] instr);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < IR_W; i++) tck_cycle(i == IR_W - 1, instr[i], b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic scan_dr(input logic [31:0] din, input int n, output logic [31:0] dout);
		logic b;
		dout = '0;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < n; i++) begin
			tck_cycle(i == n - 1, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [15:0] data);
		logic [31:0] discard;
		shift_ir(DBG_ADDR);
		scan_dr({28'h0, addr}, ADDR_W, discard);
		shift_ir(DBG_WRITE);
		scan_dr({16'h0, data}, DATA_W, discard);
		model_cfg[addr] = data & field_mask(addr);
		wait_config(expected_cfg());
	endtask

	task automatic read_reg(input logic [3:0] addr);
		logic [31:0] word;
		shift_ir(DBG_ADDR);
		scan_dr({28'h0, addr}, ADDR_W, word);
		shift_ir(DBG_READ);
		scan_dr(32'h0, DATA_W, word);
		check_value($sformatf("read of register %0d", addr), word, {16'h0, expected_read(addr)});
	endtask

	initial begin
		logic [31:0] word;
		logic [31:0] din;
		logic [3:0]  addr;
		logic        bit_out;
		reset_i = 1'b1;
		tck_i = 1'b0;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		trst_n_i = 1'b1;
		phase_est_i = '0;
		prbs_err_i = '0;
		void'($urandom(32'hc8d8db46));
		for (int i = 0; i < 16; i++) model_cfg[i] = '0;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;
		@(negedge clk);
		check_value("configuration outputs", {16'h0, cfg_obs}, 32'h0);
		check_value("tdo_o", {31'h0, tdo_o}, 32'h0);

		tap_reset();
		scan_dr(32'h0, 32, word);
		check_value("IDCODE scan", word, IDCODE_VALUE);
		shift_ir(BYPASS);
		din = $urandom();
		scan_dr(din, 32, word);
		check_value("BYPASS scan", word, {din[30:0], 1'b0});

		for (int r = 0; r < 3; r++) begin
			for (int a = 0; a < 3; a++) begin
				addr = 4'(a);
				write_reg(addr, 16'($urandom()));
				read_reg(addr);
			end
		end

		phase_est_i = 16'($urandom());
		prbs_err_i = 16'($urandom());
		read_reg(REG_PHASE);
		read_reg(REG_PRBS_ERR);
		write_reg(4'd5, 16'($urandom()));
		write_reg(4'd14, 16'($urandom()));
		write_reg(REG_PHASE, 16'($urandom()));
		read_reg(4'd5);
		read_reg(4'd14);

		write_reg(REG_RESET, 16'h0003);
		trst_n_i = 1'b0;
		repeat (6) @(negedge clk);
		trst_n_i = 1'b1;
		repeat (6) @(negedge clk);
		wait_config(expected_cfg());
		// TAP left in Test-Logic-Reset by trst_n
		tck_cycle(1'b0, 1'b0, bit_out);
		scan_dr(32'h0, 32, word);
		check_value("IDCODE scan after trst", word, IDCODE_VALUE);

		// Park in Shift-DR with IDCODE bit 0 on tdo
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		check_value("tdo_o before reset", {31'h0, tdo_o}, 32'h1);

		reset_i = 1'b1;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;
		for (int i = 0; i < 16; i++) model_cfg[i] = '0;
		wait_config(expected_cfg());

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/jtag_pkg.sv
verilog/debug_pkg.sv
verilog/jtag_pin_sync.sv
verilog/jtag_tap.sv
verilog/debug_reg_file.sv
verilog/jtag.sv
test/jtag_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module jtag_tb -f build.f
	./obj_dir/Vjtag_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
